// File: list.f
hdl/mem_pkg.sv
hdl/bank_if.sv
hdl/mem_route.sv
hdl/bank_ram.sv
hdl/bank_config.sv
hdl/mem_subsystem.sv
tests/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - hdl/mem_pkg.sv
  - hdl/bank_if.sv
  - hdl/mem_route.sv
  - hdl/bank_ram.sv
  - hdl/bank_config.sv
  - hdl/mem_subsystem.sv
  - target: test
    files:
      - tests/tb_mem_subsystem.sv

// File: tests/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

	// Upper bound on accesses over all tests, each at most 17 cycles
	localparam int access_count = 64;
	localparam int cycle_limit = access_count * 17 + 120;

	logic ram1_work_done;
	logic reset;
	logic mem_rd;
	logic mem_wr;
	logic [15:0] addr;
	logic [15:0] wdata;
	logic [15:0] pc;
	logic cfg_wr;
	logic cfg_data_sel;
	logic [3:0] cfg_wait;
	logic work_done;
	logic [15:0] feedback;
	logic [15:0] done_pc_out;

	logic [15:0] data_model [256];
	logic [15:0] insn_model [256];
	logic [15:0] data_addr [8];
	logic [15:0] insn_addr [8];
	logic [3:0] wait_list [3] = '{4'd0, 4'd15, 4'd7};
	logic [3:0] data_wait_m;
	logic [3:0] insn_wait_m;
	logic [15:0] exp_value;
	logic [15:0] data_pc;
	logic [15:0] insn_pc;
	logic [15:0] next_pc;
	logic [31:0] rng;
	int req_edges;
	int exp_lat;
	int cycles;
	int errors;
	int tests_run;
	int test_base;
	logic bank_req;

	mem_subsystem dut_i (
		.ram1_work_done (ram1_work_done),
		.reset (reset),
		.mem_rd (mem_rd),
		.mem_wr (mem_wr),
		.addr (addr),
		.wdata (wdata),
		.pc (pc),
		.cfg_wr (cfg_wr),
		.cfg_data_sel (cfg_data_sel),
		.cfg_wait (cfg_wait),
		.work_done (work_done),
		.feedback (feedback),
		.done_pc_out (done_pc_out)
	);

	always #2 ram1_work_done = ~ram1_work_done;

	assign bank_req = (mem_rd || mem_wr) && (addr != 16'hbf01);

	//////////////////////////////
	// Checks
	//////////////////////////////
	assert property (@(posedge ram1_work_done) disable iff (reset)
		(!(mem_rd || mem_wr) || addr == 16'hbf01) |-> work_done)
	else begin
		errors++;
		$display("ERROR %0t work_done: expected 1, got %b", $time, $sampled(work_done));
	end

	assert property (@(posedge ram1_work_done) disable iff (reset)
		((mem_rd || mem_wr) && addr == 16'hbf01) |-> feedback == 16'hffff)
	else begin
		errors++;
		$display("ERROR %0t feedback: expected ffff, got %h", $time, $sampled(feedback));
	end

	// Done before its time would be a stale level from the last instruction
	assert property (@(posedge ram1_work_done) disable iff (reset)
		(bank_req && req_edges < exp_lat) |-> !work_done)
	else begin
		errors++;
		$display("ERROR %0t work_done: expected 0 after %0d edges, got 1",
			$time, $sampled(req_edges));
	end

	assert property (@(posedge ram1_work_done) disable iff (reset)
		(bank_req && req_edges == exp_lat) |-> work_done)
	else begin
		errors++;
		$display("ERROR %0t work_done: expected 1 after %0d edges, got 0",
			$time, $sampled(req_edges));
	end

	assert property (@(posedge ram1_work_done) disable iff (reset)
		(bank_req && mem_rd && work_done) |-> feedback == exp_value)
	else begin
		errors++;
		$display("ERROR %0t feedback: expected %h, got %h",
			$time, $sampled(exp_value), $sampled(feedback));
	end

	assert property (@(posedge ram1_work_done) disable iff (reset)
		(bank_req && work_done) |-> done_pc_out == {data_pc[7:0], insn_pc[7:0]})
	else begin
		errors++;
		$display("ERROR %0t done_pc_out: expected %h, got %h", $time,
			$sampled({data_pc[7:0], insn_pc[7:0]}), $sampled(done_pc_out));
	end

	// Run limit
	always @(posedge ram1_work_done) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the DUT gave no answer within %0d cycles", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Drives one access and returns on the edge that sees work_done
	task automatic access(input logic write, input logic [15:0] a, input logic [15:0] d);
		logic [15:0] this_pc;
		this_pc = next_pc;
		next_pc = next_pc + 16'd1;
		mem_rd <= !write;
		mem_wr <= write;
		addr <= a;
		wdata <= d;
		pc <= this_pc;
		req_edges <= 0;
		if (a != 16'hbf01 && a[15]) begin
			if (write)
				data_model[a[7:0]] = d;
			exp_value <= data_model[a[7:0]];
			exp_lat <= data_wait_m + 1;
			data_pc <= this_pc;
		end else if (a != 16'hbf01) begin
			if (write)
				insn_model[a[7:0]] = d;
			exp_value <= insn_model[a[7:0]];
			exp_lat <= insn_wait_m + 1;
			insn_pc <= this_pc;
		end
		@(posedge ram1_work_done);
		while (!work_done) begin
			req_edges <= req_edges + 1;
			@(posedge ram1_work_done);
		end
	endtask

	task automatic idle(input int n);
		mem_rd <= 1'b0;
		mem_wr <= 1'b0;
		repeat (n) @(posedge ram1_work_done);
	endtask

	task automatic set_wait(input logic data_sel, input logic [3:0] w);
		mem_rd <= 1'b0;
		mem_wr <= 1'b0;
		cfg_wr <= 1'b1;
		cfg_data_sel <= data_sel;
		cfg_wait <= w;
		@(posedge ram1_work_done);
		cfg_wr <= 1'b0;
		if (data_sel)
			data_wait_m = w;
		else
			insn_wait_m = w;
		@(posedge ram1_work_done);
	endtask

	task automatic report(input string name);
		// One idle edge so the checks of the last access land in this test
		mem_rd <= 1'b0;
		mem_wr <= 1'b0;
		@(posedge ram1_work_done);
		tests_run++;
		$display("Test %0d, %s: %0d errors", tests_run, name, errors - test_base);
		test_base = errors;
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		int i;
		logic [15:0] a;
		ram1_work_done = 1'b0;
		reset = 1'b1;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		addr = '0;
		wdata = '0;
		pc = '0;
		cfg_wr = 1'b0;
		cfg_data_sel = 1'b0;
		cfg_wait = '0;
		exp_value = '0;
		data_pc = '0;
		insn_pc = '0;
		req_edges = 0;
		exp_lat = 0;
		cycles = 0;
		errors = 0;
		tests_run = 0;
		test_base = 0;
		data_wait_m = 4'd1;
		insn_wait_m = 4'd2;
		next_pc = 16'h0001;
		rng = 32'h05d2b391;
		repeat (3) @(posedge ram1_work_done);
		reset <= 1'b0;

		idle(2);
		access(1'b0, 16'hbf01, 16'h0);
		access(1'b1, 16'hbf01, 16'h1234);
		access(1'b0, 16'hbf01, 16'h0);
		idle(2);
		report("status and idle");

		for (i = 0; i < 8; i++) begin
			rng = xorshift(rng);
			a = {1'b1, rng[14:0]};
			if (a == 16'hbf01)
				a = 16'h8001;
			data_addr[i] = a;
			insn_addr[i] = {1'b0, rng[30:24], a[7:0]};
			access(1'b1, a, rng[31:16]);
		end
		for (i = 0; i < 8; i++)
			access(1'b0, data_addr[i], 16'h0);
		report("data bank write and read");

		// Same low bytes in the other bank
		for (i = 0; i < 8; i++) begin
			rng = xorshift(rng);
			access(1'b1, insn_addr[i], rng[15:0]);
		end
		for (i = 0; i < 8; i++)
			access(1'b0, insn_addr[i], 16'h0);
		for (i = 0; i < 8; i++)
			access(1'b0, data_addr[i], 16'h0);
		report("bank independence");

		for (i = 0; i < 3; i++) begin
			rng = xorshift(rng);
			set_wait(1'b1, wait_list[i]);
			access(1'b1, data_addr[i], rng[15:0]);
			access(1'b0, data_addr[i], 16'h0);
			set_wait(1'b0, wait_list[i]);
			access(1'b1, insn_addr[i], rng[31:16]);
			access(1'b0, insn_addr[i], 16'h0);
		end
		report("configured wait states");

		set_wait(1'b1, 4'd3);
		access(1'b0, data_addr[0], 16'h0);
		access(1'b0, data_addr[0], 16'h0);
		access(1'b1, data_addr[1], 16'hc3a5);
		access(1'b0, data_addr[1], 16'h0);
		report("back to back same bank");

		next_pc = 16'h3c7e;
		access(1'b0, data_addr[2], 16'h0);
		access(1'b0, insn_addr[2], 16'h0);
		access(1'b0, 16'hbf01, 16'h0);
		idle(2);
		report("served pc debug output");

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: hdl/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem import mem_pkg::*; (
	input logic ram1_work_done,
	input logic reset,
	input logic mem_rd,
	input logic mem_wr,
	input logic [addr_w-1:0] addr,
	input logic [value_w-1:0] wdata,
	input logic [pc_w-1:0] pc,
	input logic cfg_wr,
	input logic cfg_data_sel,
	input logic [wait_w-1:0] cfg_wait,
	output logic work_done,
	output logic [value_w-1:0] feedback,
	output logic [15:0] done_pc_out
);

	logic [wait_w-1:0] data_wait;
	logic [wait_w-1:0] insn_wait;

	bank_if data_bus ();
	bank_if insn_bus ();

	//////////////////////////////
	// Route and configuration
	//////////////////////////////
	mem_route mem_route_i (
		.ram1_work_done (ram1_work_done),
		.reset (reset),
		.mem_rd (mem_rd),
		.mem_wr (mem_wr),
		.addr (addr),
		.wdata (wdata),
		.pc (pc),
		.work_done (work_done),
		.feedback (feedback),
		.done_pc_out (done_pc_out),
		.data_bus (data_bus.route),
		.insn_bus (insn_bus.route)
	);

	bank_config bank_config_i (
		.ram1_work_done (ram1_work_done),
		.reset (reset),
		.cfg_wr (cfg_wr),
		.cfg_data_sel (cfg_data_sel),
		.cfg_wait (cfg_wait),
		.data_wait (data_wait),
		.insn_wait (insn_wait)
	);

	//////////////////////////////
	// Banks
	//////////////////////////////
	bank_ram data_bank_i (
		.ram1_work_done (ram1_work_done),
		.reset (reset),
		.wait_states (data_wait),
		.bus (data_bus.bank)
	);

	bank_ram insn_bank_i (
		.ram1_work_done (ram1_work_done),
		.reset (reset),
		.wait_states (insn_wait),
		.bus (insn_bus.bank)
	);

endmodule

// File: hdl/bank_config.sv
`timescale 1ns/1ps

module bank_config import mem_pkg::*; (
	input logic ram1_work_done,
	input logic reset,
	input logic cfg_wr,
	input logic cfg_data_sel,
	input logic [wait_w-1:0] cfg_wait,
	output logic [wait_w-1:0] data_wait,
	output logic [wait_w-1:0] insn_wait
);

	logic [wait_w-1:0] data_wait_q;
	logic [wait_w-1:0] insn_wait_q;

	//////////////////////////////
	// Wait-state registers
	//////////////////////////////
	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			data_wait_q <= data_wait_reset;
			insn_wait_q <= insn_wait_reset;
		end else if (cfg_wr) begin
			// Select high picks the data bank
			if (cfg_data_sel)
				data_wait_q <= cfg_wait;
			else
				insn_wait_q <= cfg_wait;
		end
	end

	// Banks sample these only when an access starts
	assign data_wait = data_wait_q;
	assign insn_wait = insn_wait_q;

endmodule

// File: hdl/bank_ram.sv
`timescale 1ns/1ps

module bank_ram import mem_pkg::*; (
	input logic ram1_work_done,
	input logic reset,
	input logic [wait_w-1:0] wait_states,
	bank_if.bank bus
);

	logic [value_w-1:0] mem [bank_words];
	logic [value_w-1:0] rdata;
	logic [wait_w-1:0] wait_cnt;
	logic done_q;
	logic start;
	logic finish;
	logic [bank_depth_w-1:0] index;
	bank_state_e state;

	assign index = bus.addr[bank_depth_w-1:0];

	// A request is accepted from idle, or restarts a finished bank
	assign start = bus.need_to_work && (state != BANK_WAIT);

	// Zero wait states skip the wait phase entirely
	assign finish = (state == BANK_WAIT && wait_cnt == 1) ||
		(start && wait_states == '0);

	//////////////////////////////
	// Control FSM
	//////////////////////////////
	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			state <= BANK_IDLE;
			wait_cnt <= '0;
			done_q <= 1'b0;
		end else begin
			case (state)
				BANK_IDLE, BANK_DONE: begin
					if (start) begin
						if (wait_states == '0) begin
							state <= BANK_DONE;
							done_q <= 1'b1;
						end else begin
							state <= BANK_WAIT;
							wait_cnt <= wait_states;
							done_q <= 1'b0;
						end
					end
				end
				BANK_WAIT: begin
					if (wait_cnt == 1) begin
						state <= BANK_DONE;
						done_q <= 1'b1;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				default: begin
					state <= BANK_IDLE;
					done_q <= 1'b0;
				end
			endcase
		end
	end

	// Storage access happens on the edge into BANK_DONE
	always_ff @(posedge ram1_work_done) begin
		if (finish) begin
			if (bus.wr)
				mem[index] <= bus.wdata;
			else
				rdata <= mem[index];
		end
	end

	assign bus.work_done = done_q;
	assign bus.feedback = rdata;

	assert property (@(posedge ram1_work_done) disable iff (reset)
		bus.work_done == (state == BANK_DONE));

endmodule

// File: hdl/mem_route.sv
`timescale 1ns/1ps

module mem_route import mem_pkg::*; (
	input logic ram1_work_done,
	input logic reset,
	input logic mem_rd,
	input logic mem_wr,
	input logic [addr_w-1:0] addr,
	input logic [value_w-1:0] wdata,
	input logic [pc_w-1:0] pc,
	output logic work_done,
	output logic [value_w-1:0] feedback,
	output logic [15:0] done_pc_out,
	bank_if.route data_bus,
	bank_if.route insn_bus
);

	target_e target;
	logic [pc_w-1:0] data_served;
	logic [pc_w-1:0] insn_served;
	logic data_hit;
	logic insn_hit;

	//////////////////////////////
	// Address decode
	//////////////////////////////
	always_comb begin
		if (!(mem_rd || mem_wr)) begin
			target = TARGET_NONE;
		end else if (addr == status_addr) begin
			target = TARGET_STATUS;
		end else if (addr[addr_w-1]) begin
			target = TARGET_DATA;
		end else begin
			target = TARGET_INSN;
		end
	end

	// A done level only counts if it belongs to the current instruction
	assign data_hit = data_bus.work_done && (pc == data_served);
	assign insn_hit = insn_bus.work_done && (pc == insn_served);

	// Both banks see the same request lines
	assign data_bus.wr = mem_wr;
	assign data_bus.addr = addr;
	assign data_bus.wdata = wdata;
	assign insn_bus.wr = mem_wr;
	assign insn_bus.addr = addr;
	assign insn_bus.wdata = wdata;

	always_comb begin
		data_bus.need_to_work = 1'b0;
		insn_bus.need_to_work = 1'b0;
		work_done = 1'b0;
		feedback = '0;
		case (target)
			TARGET_STATUS: begin
				work_done = 1'b1;
				feedback = status_value;
			end
			TARGET_DATA: begin
				work_done = data_hit;
				feedback = data_bus.feedback;
				data_bus.need_to_work = !data_hit;
			end
			TARGET_INSN: begin
				work_done = insn_hit;
				feedback = insn_bus.feedback;
				insn_bus.need_to_work = !insn_hit;
			end
			default: begin
				// Nothing requested so the processor may move on
				work_done = 1'b1;
			end
		endcase
	end

	//////////////////////////////
	// Served program counters
	//////////////////////////////
	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			data_served <= '0;
			insn_served <= '0;
		end else begin
			if (data_bus.need_to_work)
				data_served <= pc;
			if (insn_bus.need_to_work)
				insn_served <= pc;
		end
	end

	assign done_pc_out = {data_served[7:0], insn_served[7:0]};

	// One bank in flight at a time
	assert property (@(posedge ram1_work_done) disable iff (reset)
		!(data_bus.need_to_work && insn_bus.need_to_work));

	assert property (@(posedge ram1_work_done) disable iff (reset)
		(data_bus.need_to_work || insn_bus.need_to_work) |-> (mem_rd || mem_wr));

endmodule

// File: hdl/bank_if.sv
`timescale 1ns/1ps

interface bank_if import mem_pkg::*; ();

	// Request side, from the route block
	logic need_to_work;
	logic wr;
	logic [addr_w-1:0] addr;
	logic [value_w-1:0] wdata;

	// Answer side, from the bank
	logic work_done;
	logic [value_w-1:0] feedback;

	modport route (
		output need_to_work,
		output wr,
		output addr,
		output wdata,
		input work_done,
		input feedback
	);

	modport bank (
		input need_to_work,
		input wr,
		input addr,
		input wdata,
		output work_done,
		output feedback
	);

endinterface

// File: hdl/mem_pkg.sv
package mem_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////
	localparam int addr_w = 16;
	localparam int value_w = 16;
	localparam int pc_w = 16;

	// Fixed status location that always reads back as all ones
	localparam logic [addr_w-1:0] status_addr = 16'hbf01;
	localparam logic [value_w-1:0] status_value = '1;

	// Each bank is indexed by the low address byte
	localparam int bank_depth_w = 8;
	localparam int bank_words = 1 << bank_depth_w;

	//////////////////////////////
	// Wait states
	//////////////////////////////
	localparam int wait_w = 4;
	localparam logic [wait_w-1:0] data_wait_reset = 4'd1;
	localparam logic [wait_w-1:0] insn_wait_reset = 4'd2;

	// Where an access from the processor lands
	typedef enum logic [1:0] {
		TARGET_NONE,
		TARGET_STATUS,
		TARGET_DATA,
		TARGET_INSN
	} target_e;

	typedef enum logic [1:0] {
		BANK_IDLE,
		BANK_WAIT,
		BANK_DONE
	} bank_state_e;

endpackage
